// File: src/lc4_pkg.sv
// Shared LC4 pipeline definitions
//   Word, register index and condition code types
//   Opcode enum and the three views of an instruction word
//   Control bits and the stage records
//   Condition code helper
package lc4_pkg;

  typedef logic [15:0] word_t;     // Data or address word
  typedef logic [2:0]  reg_sel_t;  // Register index

  typedef struct packed {
    logic n;
    logic z;
    logic p;
  } nzp_t;

  // Kept opcodes only, anything else retires as a no-op
  typedef enum logic [3:0] {
    BR      = 4'b0000,
    ARITH   = 4'b0001,
    LOGIC   = 4'b0101,
    LDR     = 4'b0110,
    STR     = 4'b0111,
    CONST   = 4'b1001,
    HICONST = 4'b1101
  } opcode_t;

  typedef struct packed {
    opcode_t  opcode;
    reg_sel_t rd;
    reg_sel_t rs;
    logic [2:0] sub;  // Top bit set selects the imm5 form
    reg_sel_t rt;
  } insn_rr_t;

  typedef struct packed {
    opcode_t    opcode;
    reg_sel_t   rd;
    reg_sel_t   rs;
    logic [5:0] imm6;  // LDR/STR offset, low five bits are imm5
  } insn_ri_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [2:0] rd_nzp;  // Destination, or branch mask for BR
    logic [8:0] imm9;
  } insn_lf_t;

  typedef union packed {
    insn_rr_t rr;  // Register form
    insn_ri_t ri;  // Immediate form
    insn_lf_t lf;  // Long immediate form
  } insn_u;

  typedef struct packed {
    logic rs_re;
    logic rt_re;
    logic rf_we;
    logic nzp_we;
    logic is_load;
    logic is_store;
    logic is_branch;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    insn_u insn;
  } fd_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    insn_u    insn;
    ctrl_t    ctrl;
    reg_sel_t rs;
    reg_sel_t rt;
    reg_sel_t rd;
    word_t    rs_data;
    word_t    rt_data;
  } dx_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    ctrl_t    ctrl;
    reg_sel_t rd;
    word_t    result;      // ALU result or memory address
    word_t    store_data;
  } xm_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    ctrl_t    ctrl;
    reg_sel_t rd;
    word_t    result;
    word_t    load_data;
  } mw_t;

  // One retirement per valid cycle
  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     rf_we;
    reg_sel_t wsel;
    word_t    wdata;
    logic     nzp_we;
    nzp_t     nzp;
  } wb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  // Sign class of a word
  function automatic nzp_t nzp_of(word_t w);
    nzp_t c;
    c.n = w[15];
    c.z = (w == '0);
    c.p = !w[15] && (w != '0);
    return c;
  endfunction

endpackage

// File: src/lc4_regfile.sv
// Register file
//   Eight 16-bit registers, two read ports, one write port
//   Write-through so decode sees the retiring value
module lc4_regfile (
  input  logic              gwe,
  input  logic              i_rst,
  input  lc4_pkg::reg_sel_t i_rs,       // Read port A index
  input  lc4_pkg::reg_sel_t i_rt,       // Read port B index
  output lc4_pkg::word_t    o_rs_data,
  output lc4_pkg::word_t    o_rt_data,
  input  lc4_pkg::wb_t      i_wb        // Write port from writeback
);
  import lc4_pkg::*;

  word_t regs [8];
  logic  we;

  assign we = i_wb.valid && i_wb.rf_we;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[i_wb.wsel] <= i_wb.wdata;
    end
  end

  // Same-cycle write forwards straight to the read ports
  assign o_rs_data = (we && i_wb.wsel == i_rs) ? i_wb.wdata : regs[i_rs];
  assign o_rt_data = (we && i_wb.wsel == i_rt) ? i_wb.wdata : regs[i_rt];

endmodule

// File: src/lc4_fetch.sv
// Fetch stage
//   Program counter, PC+1, stall hold and branch redirect
//   Fetch-to-decode record register
module lc4_fetch #(
  parameter lc4_pkg::word_t RESET_PC = 16'h8200  // First fetch address
) (
  input  logic               gwe,          // Clock
  input  logic               i_rst,        // Sync reset, active high
  input  logic               i_stall,      // Load-use hold from decode
  input  lc4_pkg::redirect_t i_redirect,   // Taken branch from execute
  output lc4_pkg::word_t     o_imem_addr,  // Instruction memory address
  input  lc4_pkg::word_t     i_imem_insn,  // Instruction word, same cycle
  output lc4_pkg::fd_t       o_fd          // Record into decode
);
  import lc4_pkg::*;

  word_t pc;      // Current fetch address
  word_t pc_inc;  // Static not-taken guess

  assign pc_inc      = pc + 16'd1;
  assign o_imem_addr = pc;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      pc         <= RESET_PC;
      o_fd.valid <= 1'b0;
    end else if (i_redirect.taken) begin
      pc         <= i_redirect.target;  // Redirect wins over stall
      o_fd.valid <= 1'b0;               // Drop the wrong-path fetch
    end else if (!i_stall) begin
      pc         <= pc_inc;
      o_fd.valid <= 1'b1;
    end
    // Payload held together with the PC
    if (!i_stall) begin
      o_fd.pc   <= pc;
      o_fd.insn <= i_imem_insn;
    end
  end

endmodule

// File: src/lc4_decode.sv
// Decode stage
//   Opcode decode into control bits and register indices
//   Load-use hazard detection against the instruction in execute
//   Register file read and the decode-to-execute register
module lc4_decode (
  input  logic               gwe,
  input  logic               i_rst,
  input  lc4_pkg::fd_t       i_fd,        // Record from fetch
  input  lc4_pkg::redirect_t i_redirect,  // Flush the decode slot
  input  lc4_pkg::wb_t       i_wb,        // Register write port
  output logic               o_stall,     // Hold fetch one cycle
  output lc4_pkg::dx_t       o_dx         // Record into execute
);
  import lc4_pkg::*;

  insn_u    insn;
  ctrl_t    ctrl;
  reg_sel_t rs;
  reg_sel_t rt;
  reg_sel_t rd;
  word_t    rs_data;
  word_t    rt_data;
  logic     use_rs;   // Reads the load destination on port A
  logic     use_rt;   // Same on port B

  assign insn = i_fd.insn;

  // HICONST reads its own rd, STR keeps its data register in the rd slot
  assign rs = (insn.rr.opcode == HICONST) ? insn.rr.rd : insn.rr.rs;
  assign rt = (insn.rr.opcode == STR) ? insn.rr.rd : insn.rr.rt;
  assign rd = insn.rr.rd;

  always_comb begin
    ctrl = '0;
    case (insn.rr.opcode)
      BR: ctrl.is_branch = 1'b1;
      ARITH: begin
        if (insn.rr.sub != 3'b011) begin  // DIV falls through as a no-op
          ctrl.rs_re  = 1'b1;
          ctrl.rt_re  = !insn.rr.sub[2];
          ctrl.rf_we  = 1'b1;
          ctrl.nzp_we = 1'b1;
        end
      end
      LOGIC: begin
        ctrl.rs_re  = 1'b1;
        ctrl.rt_re  = !insn.rr.sub[2] && (insn.rr.sub != 3'b001);  // NOT has no rt
        ctrl.rf_we  = 1'b1;
        ctrl.nzp_we = 1'b1;
      end
      LDR: begin
        ctrl.rs_re   = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.nzp_we  = 1'b1;
        ctrl.is_load = 1'b1;
      end
      STR: begin
        ctrl.rs_re    = 1'b1;  // Base
        ctrl.rt_re    = 1'b1;  // Store data
        ctrl.is_store = 1'b1;
      end
      CONST: begin
        ctrl.rf_we  = 1'b1;
        ctrl.nzp_we = 1'b1;
      end
      HICONST: begin
        ctrl.rs_re  = 1'b1;  // Low byte is kept
        ctrl.rf_we  = 1'b1;
        ctrl.nzp_we = 1'b1;
      end
      default: ;  // Unsupported, retires with no writes
    endcase
  end

  // Load data only exists in writeback, branches also wait for its NZP
  assign use_rs  = ctrl.rs_re && (rs == o_dx.rd);
  assign use_rt  = ctrl.rt_re && (rt == o_dx.rd);
  assign o_stall = i_fd.valid && o_dx.valid && o_dx.ctrl.is_load &&
                   (use_rs || use_rt || ctrl.is_branch);

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_rs      (rs),
    .i_rt      (rt),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data),
    .i_wb      (i_wb)
  );

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_dx.valid <= 1'b0;
    end else begin
      o_dx.valid <= i_fd.valid && !o_stall && !i_redirect.taken;  // Bubble on hazard
    end
    o_dx.pc      <= i_fd.pc;
    o_dx.insn    <= insn;
    o_dx.ctrl    <= ctrl;
    o_dx.rs      <= rs;
    o_dx.rt      <= rt;
    o_dx.rd      <= rd;
    o_dx.rs_data <= rs_data;
    o_dx.rt_data <= rt_data;
  end

endmodule

// File: src/lc4_execute.sv
// Execute stage
//   Memory-to-execute and writeback-to-execute operand bypass
//   ALU for arithmetic, logic, constants and address generation
//   Condition code forwarding and branch resolution
//   Execute-to-memory register
module lc4_execute (
  input  logic               gwe,
  input  logic               i_rst,
  input  lc4_pkg::dx_t       i_dx,        // Record from decode
  input  lc4_pkg::wb_t       i_wb,        // Retiring instruction
  input  lc4_pkg::nzp_t      i_nzp_reg,   // Committed condition code
  output lc4_pkg::redirect_t o_redirect,  // Taken branch to fetch/decode
  output lc4_pkg::xm_t       o_xm         // Record into memory
);
  import lc4_pkg::*;

  insn_u insn;
  word_t rs_val;   // Operand A after bypass
  word_t rt_val;   // Operand B after bypass
  word_t pc_inc;
  word_t imm5_sx;
  word_t imm6_sx;
  word_t imm9_sx;
  word_t result;
  nzp_t  nzp_cur;  // Condition code seen by a branch here

  // Nearest older writer wins, load results are not ready in memory stage
  function automatic word_t bypass(reg_sel_t sel, word_t rf_data, xm_t xm, wb_t wb);
    if (xm.valid && xm.ctrl.rf_we && !xm.ctrl.is_load && xm.rd == sel) begin
      return xm.result;
    end else if (wb.valid && wb.rf_we && wb.wsel == sel) begin
      return wb.wdata;
    end
    return rf_data;
  endfunction

  assign insn   = i_dx.insn;
  assign rs_val = bypass(i_dx.rs, i_dx.rs_data, o_xm, i_wb);
  assign rt_val = bypass(i_dx.rt, i_dx.rt_data, o_xm, i_wb);

  assign pc_inc  = i_dx.pc + 16'd1;
  assign imm5_sx = {{11{insn.ri.imm6[4]}}, insn.ri.imm6[4:0]};
  assign imm6_sx = {{10{insn.ri.imm6[5]}}, insn.ri.imm6};
  assign imm9_sx = {{7{insn.lf.imm9[8]}}, insn.lf.imm9};

  // A load in memory never meets a branch here, decode holds the branch back
  always_comb begin
    if (o_xm.valid && o_xm.ctrl.nzp_we) begin
      nzp_cur = nzp_of(o_xm.result);
    end else if (i_wb.valid && i_wb.nzp_we) begin
      nzp_cur = i_wb.nzp;
    end else begin
      nzp_cur = i_nzp_reg;
    end
  end

  assign o_redirect.taken  = i_dx.valid && i_dx.ctrl.is_branch &&
                             |(insn.lf.rd_nzp & nzp_cur);
  assign o_redirect.target = pc_inc + imm9_sx;

  always_comb begin
    result = '0;
    case (insn.rr.opcode)
      ARITH: begin
        if (insn.rr.sub[2]) begin
          result = rs_val + imm5_sx;  // ADD imm5
        end else begin
          case (insn.rr.sub[1:0])
            2'b00:   result = rs_val + rt_val;
            2'b01:   result = rs_val * rt_val;
            2'b10:   result = rs_val - rt_val;
            default: result = '0;
          endcase
        end
      end
      LOGIC: begin
        if (insn.rr.sub[2]) begin
          result = rs_val & imm5_sx;  // AND imm5
        end else begin
          case (insn.rr.sub[1:0])
            2'b00:   result = rs_val & rt_val;
            2'b01:   result = ~rs_val;
            2'b10:   result = rs_val | rt_val;
            default: result = rs_val ^ rt_val;
          endcase
        end
      end
      LDR, STR: result = rs_val + imm6_sx;                     // Effective address
      CONST:    result = imm9_sx;
      HICONST:  result = {insn.lf.imm9[7:0], rs_val[7:0]};
      BR:       result = o_redirect.target;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_xm.valid <= 1'b0;
    end else begin
      o_xm.valid <= i_dx.valid;  // Branch itself still retires
    end
    o_xm.pc         <= i_dx.pc;
    o_xm.ctrl       <= i_dx.ctrl;
    o_xm.rd         <= i_dx.rd;
    o_xm.result     <= result;
    o_xm.store_data <= rt_val;
  end

endmodule

// File: src/lc4_memory.sv
// Memory stage
//   Data memory port for loads and stores
//   Memory-to-writeback register with the load data
module lc4_memory (
  input  logic           gwe,
  input  logic           i_rst,
  input  lc4_pkg::xm_t   i_xm,          // Record from execute
  output lc4_pkg::word_t o_dmem_addr,   // Zero unless load or store
  output logic           o_dmem_we,     // Store commits at the clock edge
  output lc4_pkg::word_t o_dmem_wdata,
  input  lc4_pkg::word_t i_dmem_rdata,  // Read data, same cycle
  output lc4_pkg::mw_t   o_mw           // Record into writeback
);

  logic mem_op;  // Valid load or store in this stage

  assign mem_op       = i_xm.valid && (i_xm.ctrl.is_load || i_xm.ctrl.is_store);
  assign o_dmem_addr  = mem_op ? i_xm.result : '0;
  assign o_dmem_we    = i_xm.valid && i_xm.ctrl.is_store;
  assign o_dmem_wdata = i_xm.store_data;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_mw.valid <= 1'b0;
    end else begin
      o_mw.valid <= i_xm.valid;  // Never stalls
    end
    o_mw.pc        <= i_xm.pc;
    o_mw.ctrl      <= i_xm.ctrl;
    o_mw.rd        <= i_xm.rd;
    o_mw.result    <= i_xm.result;
    o_mw.load_data <= i_dmem_rdata;
  end

endmodule

// File: src/lc4_writeback.sv
// Writeback stage
//   Result selection between load data and ALU result
//   Condition code generation and the NZP register
//   Retire record
module lc4_writeback (
  input  logic          gwe,
  input  logic          i_rst,
  input  lc4_pkg::mw_t  i_mw,       // Record from memory
  output lc4_pkg::wb_t  o_wb,       // Retire record, combinational
  output lc4_pkg::nzp_t o_nzp_reg   // Committed condition code
);
  import lc4_pkg::*;

  word_t wdata;
  nzp_t  nzp_new;

  assign wdata   = i_mw.ctrl.is_load ? i_mw.load_data : i_mw.result;
  assign nzp_new = nzp_of(wdata);

  always_comb begin
    o_wb.valid  = i_mw.valid;
    o_wb.pc     = i_mw.pc;
    o_wb.rf_we  = i_mw.valid && i_mw.ctrl.rf_we;
    o_wb.wsel   = i_mw.rd;
    o_wb.wdata  = wdata;
    o_wb.nzp_we = i_mw.valid && i_mw.ctrl.nzp_we;
    o_wb.nzp    = nzp_new;
  end

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_nzp_reg <= '0;
    end else if (i_mw.valid && i_mw.ctrl.nzp_we) begin
      o_nzp_reg <= nzp_new;  // Updated on retire only
    end
  end

endmodule

// File: src/lc4_pipeline.sv
// LC4 five-stage pipeline top level
//   Fetch, decode, execute, memory and writeback instances
//   Stall, redirect and retire feedback wiring
module lc4_pipeline #(
  parameter lc4_pkg::word_t RESET_PC = 16'h8200  // Boot address
) (
  input  logic           gwe,           // Clock
  input  logic           i_rst,         // Sync reset, active high
  output lc4_pkg::word_t o_imem_addr,
  input  lc4_pkg::word_t i_imem_insn,
  output lc4_pkg::word_t o_dmem_addr,
  output logic           o_dmem_we,
  output lc4_pkg::word_t o_dmem_wdata,
  input  lc4_pkg::word_t i_dmem_rdata,
  output lc4_pkg::wb_t   o_wb           // One record per retirement
);
  import lc4_pkg::*;

  fd_t       fd;
  dx_t       dx;
  xm_t       xm;
  mw_t       mw;
  redirect_t redirect;  // Taken branch from execute
  nzp_t      nzp_reg;
  logic      stall;     // Load-use hold

  lc4_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .gwe         (gwe),
    .i_rst       (i_rst),
    .i_stall     (stall),
    .i_redirect  (redirect),
    .o_imem_addr (o_imem_addr),
    .i_imem_insn (i_imem_insn),
    .o_fd        (fd)
  );

  lc4_decode u_decode (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_fd       (fd),
    .i_redirect (redirect),
    .i_wb       (o_wb),
    .o_stall    (stall),
    .o_dx       (dx)
  );

  lc4_execute u_execute (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_dx       (dx),
    .i_wb       (o_wb),
    .i_nzp_reg  (nzp_reg),
    .o_redirect (redirect),
    .o_xm       (xm)
  );

  lc4_memory u_memory (
    .gwe          (gwe),
    .i_rst        (i_rst),
    .i_xm         (xm),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_rdata (i_dmem_rdata),
    .o_mw         (mw)
  );

  lc4_writeback u_writeback (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_mw      (mw),
    .o_wb      (o_wb),
    .o_nzp_reg (nzp_reg)
  );

endmodule

// File: bench/lc4_program.svh
// Test program and data memory contents
//   prog_word maps a fetch address to its instruction word
//   data_init gives the power-up value of every data address
// Straight-line code from 8200h that ends in a branch-to-self

function automatic word_t prog_word(word_t addr);
  case (addr)
    16'h8200: return 16'h9040;  // CONST   R0, #64
    16'h8201: return 16'h93fd;  // CONST   R1, #-3
    16'h8202: return 16'hd312;  // HICONST R1, #12h (right after its CONST)
    16'h8203: return 16'h1440;  // ADD     R2, R1, R0
    16'h8204: return 16'h1689;  // MUL     R3, R2, R1
    16'h8205: return 16'h18d2;  // SUB     R4, R3, R2
    16'h8206: return 16'h5b19;  // XOR     R5, R4, R1
    16'h8207: return 16'h7a02;  // STR     R5, R0, #2 (data from memory stage)
    16'h8208: return 16'h6c02;  // LDR     R6, R0, #2 (reads the store back)
    16'h8209: return 16'h1fa5;  // ADD     R7, R6, #5 (load-use stall)
    16'h820a: return 16'h6c01;  // LDR     R6, R0, #1
    16'h820b: return 16'h0801;  // BRn     #1 (load then branch, taken)
    16'h820c: return 16'h9e00;  // CONST   R7, #0 (wrong path)
    16'h820d: return 16'h5588;  // NOT     R2, R6
    16'h820e: return 16'h0803;  // BRn     #3 (NZP from memory stage, not taken)
    16'h820f: return 16'h5696;  // OR      R3, R2, R6
    16'h8210: return 16'h58ff;  // AND     R4, R3, #-1
    16'h8211: return 16'h9a00;  // CONST   R5, #0
    16'h8212: return 16'h783f;  // STR     R4, R0, #-1 (data from writeback)
    16'h8213: return 16'h0401;  // BRz     #1 (NZP from writeback, taken)
    16'h8214: return 16'h1b61;  // ADD     R5, R5, #1 (wrong path)
    16'h8215: return 16'h1d54;  // SUB     R6, R5, R4
    16'h8216: return 16'h0fff;  // BRnzp   #-1 (spin here)
    default:  return 16'h0000;  // Never-taken BR
  endcase
endfunction

// Byte swap plus a constant so every address bit matters
function automatic word_t data_init(word_t a);
  return {a[7:0], a[15:8]} ^ 16'hc35a;
endfunction

// File: bench/lc4_pipeline_props.sv
// Architectural checker for the LC4 pipeline
//   Reference model of PC, registers, NZP and data memory
//   Model steps once per retirement
//   Assertions on reset state, retire record and data port
module lc4_pipeline_props #(
  parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
  input logic           gwe,
  input logic           i_rst,
  input lc4_pkg::word_t i_imem_addr,
  input lc4_pkg::word_t i_dmem_addr,
  input logic           i_dmem_we,
  input lc4_pkg::word_t i_dmem_wdata,
  input lc4_pkg::wb_t   i_wb
);
  timeunit 1ns;
  timeprecision 100ps;
  import lc4_pkg::*;

  `include "lc4_program.svh"

  word_t      m_pc;
  word_t      m_regs [8];
  logic [2:0] m_nzp;           // n, z, p
  word_t      m_dmem [65536];  // Data copy
  int         err_count = 0;   // Failed assertions so far

  word_t      insn;     // Next instruction in program order
  word_t      va;
  word_t      vb;
  word_t      imm5;
  word_t      imm6;
  word_t      imm9;
  logic       e_rf_we;
  logic       e_load;
  logic       e_store;
  reg_sel_t   e_wsel;
  word_t      e_wdata;
  word_t      e_addr;
  word_t      e_sdata;
  word_t      e_next;   // PC after this instruction

  function automatic logic [2:0] sign_class(word_t w);
    return {$signed(w) < 0, w == 16'h0000, $signed(w) > 0};
  endfunction

  assign insn = prog_word(m_pc);
  assign va   = m_regs[insn[8:6]];
  assign vb   = m_regs[insn[2:0]];
  assign imm5 = {{11{insn[4]}}, insn[4:0]};
  assign imm6 = {{10{insn[5]}}, insn[5:0]};
  assign imm9 = {{7{insn[8]}}, insn[8:0]};

  always_comb begin
    e_rf_we = 1'b0;
    e_load  = 1'b0;
    e_store = 1'b0;
    e_wsel  = insn[11:9];
    e_wdata = '0;
    e_addr  = '0;
    e_sdata = '0;
    e_next  = m_pc + 16'd1;
    case (insn[15:12])
      4'h0: if ((insn[11:9] & m_nzp) != 3'b000) e_next = m_pc + 16'd1 + imm9;  // BR
      4'h1: begin
        e_rf_we = insn[5] || insn[4:3] != 2'b11;  // DIV is not kept
        if (insn[5])              e_wdata = va + imm5;
        else if (insn[4:3] == 2'b00) e_wdata = va + vb;
        else if (insn[4:3] == 2'b01) e_wdata = va * vb;
        else                      e_wdata = va - vb;
      end
      4'h5: begin
        e_rf_we = 1'b1;
        if (insn[5])              e_wdata = va & imm5;
        else if (insn[4:3] == 2'b00) e_wdata = va & vb;
        else if (insn[4:3] == 2'b01) e_wdata = ~va;
        else if (insn[4:3] == 2'b10) e_wdata = va | vb;
        else                      e_wdata = va ^ vb;
      end
      4'h6: begin  // LDR
        e_rf_we = 1'b1;
        e_load  = 1'b1;
        e_addr  = va + imm6;
        e_wdata = m_dmem[e_addr];
      end
      4'h7: begin  // STR data register sits in bits 11:9
        e_store = 1'b1;
        e_addr  = va + imm6;
        e_sdata = m_regs[insn[11:9]];
      end
      4'h9: begin
        e_rf_we = 1'b1;
        e_wdata = imm9;
      end
      4'hd: begin
        e_rf_we = 1'b1;
        e_wdata = {insn[7:0], m_regs[insn[11:9]][7:0]};
      end
      default: ;  // Anything else retires with no effect
    endcase
  end

  initial begin
    for (int a = 0; a < 65536; a++) begin
      m_dmem[16'(a)] = data_init(16'(a));
    end
  end

  always @(posedge gwe) begin
    if (i_rst) begin
      m_pc  <= RESET_PC;
      m_nzp <= 3'b000;
      for (int r = 0; r < 8; r++) begin
        m_regs[3'(r)] <= '0;
      end
    end else if (i_wb.valid) begin
      m_pc <= e_next;
      if (e_rf_we) begin
        m_regs[e_wsel] <= e_wdata;
        m_nzp          <= sign_class(e_wdata);  // Every kept NZP writer writes a register
      end
      if (e_store) begin
        m_dmem[e_addr] <= e_sdata;
      end
    end
  end

  a_reset: assert property (@(posedge gwe)
    i_rst |=> !i_wb.valid && !i_dmem_we && i_imem_addr == RESET_PC)
  else begin
    err_count++;
    $error("Mismatch at %0t: reset state, fetch address %h", $time, $sampled(i_imem_addr));
  end

  a_pc: assert property (@(posedge gwe) disable iff (i_rst)
    i_wb.valid |-> i_wb.pc == m_pc)
  else begin
    err_count++;
    $error("Mismatch at %0t: retired pc %h, model pc %h", $time,
           $sampled(i_wb.pc), $sampled(m_pc));
  end

  a_write: assert property (@(posedge gwe) disable iff (i_rst)
    i_wb.valid |-> i_wb.rf_we == e_rf_we &&
                   (!e_rf_we || (i_wb.wsel == e_wsel && i_wb.wdata == e_wdata)))
  else begin
    err_count++;
    $error("Mismatch at %0t: pc %h wrote R%0d=%h, model R%0d=%h", $time, $sampled(m_pc),
           $sampled(i_wb.wsel), $sampled(i_wb.wdata), $sampled(e_wsel), $sampled(e_wdata));
  end

  // NZP writers are exactly the register writers of the kept subset
  a_nzp: assert property (@(posedge gwe) disable iff (i_rst)
    i_wb.valid |-> i_wb.nzp_we == e_rf_we &&
                   (!e_rf_we || i_wb.nzp == sign_class(e_wdata)))
  else begin
    err_count++;
    $error("Mismatch at %0t: pc %h nzp_we %b nzp %b, model nzp_we %b nzp %b", $time,
           $sampled(m_pc), $sampled(i_wb.nzp_we), $sampled(i_wb.nzp),
           $sampled(e_rf_we), sign_class($sampled(e_wdata)));
  end

  // Store enable comes exactly one cycle ahead of the retire record
  a_store: assert property (@(posedge gwe) disable iff (i_rst)
    i_wb.valid && e_store |-> $past(i_dmem_we) && $past(i_dmem_addr) == e_addr &&
                              $past(i_dmem_wdata) == e_sdata)
  else begin
    err_count++;
    $error("Mismatch at %0t: store of pc %h, model [%h]=%h", $time, $sampled(m_pc),
           $sampled(e_addr), $sampled(e_sdata));
  end

  a_quiet: assert property (@(posedge gwe) disable iff (i_rst)
    i_wb.valid && !e_store |-> !$past(i_dmem_we) &&
                               $past(i_dmem_addr) == (e_load ? e_addr : 16'h0000))
  else begin
    err_count++;
    $error("Mismatch at %0t: data port activity for pc %h", $time, $sampled(m_pc));
  end

endmodule

bind lc4_pipeline lc4_pipeline_props #(
  .RESET_PC (RESET_PC)
) u_props (
  .gwe          (gwe),
  .i_rst        (i_rst),
  .i_imem_addr  (o_imem_addr),
  .i_dmem_addr  (o_dmem_addr),
  .i_dmem_we    (o_dmem_we),
  .i_dmem_wdata (o_dmem_wdata),
  .i_wb         (o_wb)
);

// File: bench/lc4_tb.sv
// Testbench for the LC4 pipeline
//   Clock and reset generation
//   Instruction ROM and data RAM, driven on the falling edge
//   Retirement count with timeout, checker watch and final status
module lc4_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import lc4_pkg::*;

  `include "lc4_program.svh"

  localparam word_t RESET_PC    = 16'h8200;
  localparam int    RETIRE_GOAL = 24;   // 20 straight-line retirements plus 4 loop spins
  localparam int    MAX_CYCLES  = 200;

  logic  gwe;
  logic  i_rst;
  word_t imem_addr;
  word_t imem_insn;
  word_t dmem_addr;
  logic  dmem_we;
  word_t dmem_wdata;
  word_t dmem_rdata;
  wb_t   wb;             // Retire record from the DUT
  word_t dmem [65536];   // Data RAM
  int    retired;        // Retirements seen so far

  lc4_pipeline #(
    .RESET_PC (RESET_PC)
  ) dut (
    .gwe          (gwe),
    .i_rst        (i_rst),
    .o_imem_addr  (imem_addr),
    .i_imem_insn  (imem_insn),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_wb         (wb)
  );

  initial begin
    gwe = 1'b0;
    forever #2 gwe = ~gwe;  // 4 ns period
  end

  // Both memories answer the address of the current cycle
  always @(negedge gwe) begin
    if (dmem_we) begin
      dmem[dmem_addr] = dmem_wdata;  // Lands before the next memory-stage read
    end
    imem_insn  <= prog_word(imem_addr);
    dmem_rdata <= dmem[dmem_addr];
  end

  // Counts retire records, gives up after limit cycles
  task automatic wait_for_retirements(input int goal, input int limit);
    int cycles;
    cycles = 0;
    while (retired < goal && cycles < limit) begin
      @(negedge gwe);
      if (wb.valid) begin
        retired++;
      end
      cycles++;
    end
  endtask

  initial begin
    i_rst      = 1'b1;
    imem_insn  = '0;
    dmem_rdata = '0;
    retired    = 0;
    for (int a = 0; a < 65536; a++) begin
      dmem[16'(a)] = data_init(16'(a));
    end
    repeat (8) @(posedge gwe);
    @(negedge gwe);
    i_rst = 1'b0;
    wait_for_retirements(RETIRE_GOAL, MAX_CYCLES);
    if (retired >= RETIRE_GOAL && dut.u_props.err_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "Run ended with %0d of %0d retirements and %0d failed assertions",
             retired, RETIRE_GOAL, dut.u_props.err_count);
    end
  end

  // Stops at the first assertion the bound checker fails
  initial begin : watch_checker
    int cycles;
    cycles = 0;
    while (dut.u_props.err_count == 0 && cycles < MAX_CYCLES + 16) begin
      @(negedge gwe);
      cycles++;
    end
    if (dut.u_props.err_count != 0) begin
      $display("STATUS: FAIL");
      $fatal(1, "Pipeline checker failed an assertion at %0t", $time);
    end
  end

endmodule

// File: sim.f
+incdir+bench
src/lc4_pkg.sv
src/lc4_regfile.sv
src/lc4_fetch.sv
src/lc4_decode.sv
src/lc4_execute.sv
src/lc4_memory.sv
src/lc4_writeback.sv
src/lc4_pipeline.sv
bench/lc4_pipeline_props.sv
bench/lc4_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module lc4_tb -f sim.f
	./obj_dir/Vlc4_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
